/* logic/tracker_pkg.sv */
/*
 * tracker display package
 * pixel, frame-buffer word and raster coordinate types shared by the
 * display path, plus the fixed look-ahead, marker size and marker colors
 */
`default_nettype none

package tracker_pkg;

   ////////////////////////////////////////////////////////////
   // pixel formats
   ////////////////////////////////////////////////////////////

   // camera pixel as stored, 6-6-6 with red on top
   typedef logic [17:0] pixel_t;

   // display pixel, 8-8-8 with red on top
   typedef logic [23:0] rgb_t;

   ////////////////////////////////////////////////////////////
   // frame buffer
   ////////////////////////////////////////////////////////////

   // two pixels per word, even pixel in bits 35:18
   typedef logic [35:0] vram_word_t;

   // line number in the upper 10 bits, word index (h / 2) below it
   typedef logic [18:0] vram_addr_t;

   ////////////////////////////////////////////////////////////
   // raster coordinates
   ////////////////////////////////////////////////////////////

   typedef logic [10:0] hcount_t;
   typedef logic [9:0]  vcount_t;

   // read address runs this many pixels ahead of the raster
   localparam int FETCH_LOOKAHEAD = 4;

   // width of each crosshair bar
   localparam int MARK_THICK = 4;

   // light red and light green crosshairs
   localparam rgb_t RED_MARK   = 24'hFF_30_30;
   localparam rgb_t GREEN_MARK = 24'h30_FF_30;

endpackage

`default_nettype wire

/* logic/raster_timing.sv */
/*
 * raster timing generator
 * pixel and line counters with registered sync pulses and blanking,
 * frame structure set by parameters (XGA by default)
 */
`default_nettype none

module raster_timing import tracker_pkg::*; #(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806
) (
   input  wire logic clk,
   input  wire logic rst_n,
   output hcount_t   hcount,
   output vcount_t   vcount,
   output logic      hsync,
   output logic      vsync,
   output logic      blank
);

   // horizontal and vertical blanking kept apart, blank is their OR
   logic    hblank;
   logic    vblank;

   logic    h_end;
   logic    v_end;
   hcount_t next_hcount;
   vcount_t next_vcount;
   logic    next_hblank;
   logic    next_vblank;
   logic    next_hsync;
   logic    next_vsync;

   ////////////////////////////////////////////////////////////
   // next state from the compare points
   ////////////////////////////////////////////////////////////

   always_comb begin
      h_end = (hcount == hcount_t'(H_TOTAL - 1));
      v_end = (vcount == vcount_t'(V_TOTAL - 1));

      next_hcount = h_end ? '0 : hcount + 1'b1;
      // line counter only moves on the last pixel of a line
      next_vcount = h_end ? (v_end ? '0 : vcount + 1'b1) : vcount;

      // each flag is set one pixel before its region and held
      next_hblank = h_end ? 1'b0 :
                    (hcount == hcount_t'(H_ACTIVE - 1)) ? 1'b1 : hblank;
      next_hsync  = (hcount == hcount_t'(H_SYNC_START - 1)) ? 1'b0 :
                    (hcount == hcount_t'(H_SYNC_END - 1))   ? 1'b1 : hsync;

      next_vblank = (h_end && v_end) ? 1'b0 :
                    (h_end && vcount == vcount_t'(V_ACTIVE - 1)) ? 1'b1 : vblank;
      next_vsync  = (h_end && vcount == vcount_t'(V_SYNC_START - 1)) ? 1'b0 :
                    (h_end && vcount == vcount_t'(V_SYNC_END - 1))   ? 1'b1 : vsync;
   end

   // syncs idle high, counters at the top left corner
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= next_hcount;
         vcount <= next_vcount;
         hblank <= next_hblank;
         vblank <= next_vblank;
         hsync  <= next_hsync;
         vsync  <= next_vsync;
         blank  <= next_hblank | next_vblank;
      end
   end

   // counters never leave the frame
   a_counts_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
      (hcount < hcount_t'(H_TOTAL)) && (vcount < vcount_t'(V_TOTAL)));

endmodule

`default_nettype wire

/* logic/frame_fetch.sv */
/*
 * frame buffer fetch
 * forms the read address ahead of the raster, latches the returning
 * words and splits each into two camera pixels, black outside the window
 */
`default_nettype none

module frame_fetch import tracker_pkg::*; #(
   parameter int H_TOTAL      = 1344,
   parameter int V_TOTAL      = 806,
   parameter int CAM_W        = 720,
   parameter int CAM_H        = 460,
   parameter int READ_LATENCY = 2
) (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire hcount_t    hcount,
   input  wire vcount_t    vcount,
   output vram_addr_t      vram_addr,
   input  wire vram_word_t vram_data,
   output pixel_t          cam_pixel
);

   // word index width below the line field
   localparam int IDX_W = $bits(vram_addr_t) - $bits(vcount_t);
   // the look-ahead wraps to the next line from this pixel on
   localparam int WRAP_H = H_TOTAL - FETCH_LOOKAHEAD;
   // parity of hcount when the wanted word sits on vram_data
   // holds for latencies up to FETCH_LOOKAHEAD - 2
   localparam logic CAPTURE_PARITY = 1'(READ_LATENCY % 2);

   logic       wrap_line;
   hcount_t    fetch_h;
   vcount_t    fetch_v;
   logic       in_window;
   vram_word_t next_word;
   vram_word_t cur_word;

   ////////////////////////////////////////////////////////////
   // look-ahead address
   ////////////////////////////////////////////////////////////

   always_comb begin
      wrap_line = (hcount >= hcount_t'(WRAP_H));
      fetch_h   = wrap_line ? hcount - hcount_t'(WRAP_H)
                            : hcount + hcount_t'(FETCH_LOOKAHEAD);
      // past the last line the fetch goes back to line 0
      if (!wrap_line)
         fetch_v = vcount;
      else if (vcount == vcount_t'(V_TOTAL - 1))
         fetch_v = '0;
      else
         fetch_v = vcount + 1'b1;
   end

   // two pixels share a word, so drop bit 0 of the position
   assign vram_addr = {fetch_v, fetch_h[IDX_W:1]};

   ////////////////////////////////////////////////////////////
   // word latching
   ////////////////////////////////////////////////////////////

   // next_word grabs each new word as it arrives
   // cur_word takes it on the odd pixel just before its even pixel
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         next_word <= '0;
         cur_word  <= '0;
      end else begin
         if (hcount[0] == CAPTURE_PARITY)
            next_word <= vram_data;
         if (hcount[0])
            cur_word <= next_word;
      end
   end

   // upper half for even pixels, lower half for odd
   assign in_window = (hcount < hcount_t'(CAM_W)) && (vcount < vcount_t'(CAM_H));
   assign cam_pixel = !in_window ? '0 :
                      hcount[0]  ? cur_word[17:0] : cur_word[35:18];

   // address line field stays inside the frame
   a_addr_line_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
      vram_addr[$bits(vram_addr_t)-1 -: $bits(vcount_t)] < vcount_t'(V_TOTAL));

endmodule

`default_nettype wire

/* logic/marker_overlay.sv */
/*
 * marker overlay
 * button toggles between the green and red tracking view, the selected
 * view's crosshair is drawn over the widened camera pixel
 */
`default_nettype none

module marker_overlay import tracker_pkg::*; #(
   parameter int CAM_W = 720,
   parameter int CAM_H = 460
) (
   input  wire logic    clk,
   input  wire logic    rst_n,
   input  wire logic    select_button,
   input  wire hcount_t hcount,
   input  wire vcount_t vcount,
   input  wire pixel_t  cam_pixel,
   input  wire hcount_t red_x,
   input  wire vcount_t red_y,
   input  wire hcount_t green_x,
   input  wire vcount_t green_y,
   output rgb_t         view_pixel
);

   // 0 = green view, 1 = red view
   logic                  view_red;
   logic                  button_prev;
   logic                  button_rise;

   hcount_t               mark_x;
   vcount_t               mark_y;
   rgb_t                  mark_color;
   // one bit wider so x + MARK_THICK cannot wrap
   logic [$bits(hcount_t):0] mark_x_end;
   logic [$bits(vcount_t):0] mark_y_end;
   logic                  on_vbar;
   logic                  on_hbar;

   ////////////////////////////////////////////////////////////
   // view select
   ////////////////////////////////////////////////////////////

   assign button_rise = select_button & ~button_prev;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         button_prev <= 1'b0;
         view_red    <= 1'b0;
      end else begin
         button_prev <= select_button;
         // a held button toggles only once
         if (button_rise)
            view_red <= ~view_red;
      end
   end

   ////////////////////////////////////////////////////////////
   // crosshair
   ////////////////////////////////////////////////////////////

   always_comb begin
      mark_x     = view_red ? red_x : green_x;
      mark_y     = view_red ? red_y : green_y;
      mark_color = view_red ? RED_MARK : GREEN_MARK;

      mark_x_end = {1'b0, mark_x} + ($bits(hcount_t)+1)'(MARK_THICK);
      mark_y_end = {1'b0, mark_y} + ($bits(vcount_t)+1)'(MARK_THICK);

      // vertical bar spans the camera height
      on_vbar = (hcount >= mark_x) && ({1'b0, hcount} < mark_x_end) &&
                (vcount < vcount_t'(CAM_H));
      // horizontal bar spans the camera width
      on_hbar = (vcount >= mark_y) && ({1'b0, vcount} < mark_y_end) &&
                (hcount < hcount_t'(CAM_W));
   end

   // camera pixel widened by two zero bits per component
   assign view_pixel = (on_vbar || on_hbar) ? mark_color :
                       {cam_pixel[17:12], 2'b00,
                        cam_pixel[11:6],  2'b00,
                        cam_pixel[5:0],   2'b00};

endmodule

`default_nettype wire

/* logic/video_out.sv */
/*
 * video output stage
 * registers pixel, syncs and blank together, splits the pixel into
 * 8-bit color channels and drives blank active low
 */
`default_nettype none

module video_out import tracker_pkg::*; (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire rgb_t       view_pixel,
   input  wire logic       hsync,
   input  wire logic       vsync,
   input  wire logic       blank,
   output logic [7:0]      red,
   output logic [7:0]      green,
   output logic [7:0]      blue,
   output logic            hsync_out,
   output logic            vsync_out,
   output logic            blank_b
);

   // pixel and timing share one stage so they stay aligned
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         red       <= '0;
         green     <= '0;
         blue      <= '0;
         hsync_out <= 1'b1;
         vsync_out <= 1'b1;
         blank_b   <= 1'b0;
      end else begin
         red       <= view_pixel[23:16];
         green     <= view_pixel[15:8];
         blue      <= view_pixel[7:0];
         hsync_out <= hsync;
         vsync_out <= vsync;
         blank_b   <= ~blank;
      end
   end

   // sync pulses lie inside blanking, relies on the raster parameters
   a_sync_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
      (!hsync_out || !vsync_out) |-> !blank_b);

endmodule

`default_nettype wire

/* logic/tracker_display_top.sv */
/*
 * hand tracker display path
 * raster timing, frame buffer fetch, crosshair overlay and output stage
 */
`default_nettype none

module tracker_display_top import tracker_pkg::*; #(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806,
   parameter int CAM_W        = 720,
   parameter int CAM_H        = 460,
   parameter int READ_LATENCY = 2
) (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       select_button,
   input  wire hcount_t    red_x,
   input  wire vcount_t    red_y,
   input  wire hcount_t    green_x,
   input  wire vcount_t    green_y,
   // external frame buffer read port
   output vram_addr_t      vram_addr,
   input  wire vram_word_t vram_data,
   output logic [7:0]      red,
   output logic [7:0]      green,
   output logic [7:0]      blue,
   output logic            hsync,
   output logic            vsync,
   output logic            blank_b
);

   ////////////////////////////////////////////////////////////
   // raster
   ////////////////////////////////////////////////////////////

   hcount_t hcount;
   vcount_t vcount;
   logic    raster_hsync;
   logic    raster_vsync;
   logic    raster_blank;
   pixel_t  cam_pixel;
   rgb_t    view_pixel;

   raster_timing #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL)
   ) raster_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (raster_hsync),
      .vsync  (raster_vsync),
      .blank  (raster_blank)
   );

   ////////////////////////////////////////////////////////////
   // pixel path
   ////////////////////////////////////////////////////////////

   frame_fetch #(
      .H_TOTAL      (H_TOTAL),
      .V_TOTAL      (V_TOTAL),
      .CAM_W        (CAM_W),
      .CAM_H        (CAM_H),
      .READ_LATENCY (READ_LATENCY)
   ) fetch_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .vcount    (vcount),
      .vram_addr (vram_addr),
      .vram_data (vram_data),
      .cam_pixel (cam_pixel)
   );

   marker_overlay #(
      .CAM_W (CAM_W),
      .CAM_H (CAM_H)
   ) overlay_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .select_button (select_button),
      .hcount        (hcount),
      .vcount        (vcount),
      .cam_pixel     (cam_pixel),
      .red_x         (red_x),
      .red_y         (red_y),
      .green_x       (green_x),
      .green_y       (green_y),
      .view_pixel    (view_pixel)
   );

   // one register stage to the pins
   video_out out_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .view_pixel (view_pixel),
      .hsync      (raster_hsync),
      .vsync      (raster_vsync),
      .blank      (raster_blank),
      .red        (red),
      .green      (green),
      .blue       (blue),
      .hsync_out  (hsync),
      .vsync_out  (vsync),
      .blank_b    (blank_b)
   );

endmodule

`default_nettype wire

/* test/tracker_tb.sv */
/*
 * testbench for the hand tracker display path
 * small frame, frame buffer modelled as a fixed latency delay line,
 * pixels and syncs checked against the vector file
 */
`default_nettype none

module tracker_tb import tracker_pkg::*; ();

   localparam int H_ACTIVE     = 16;
   localparam int H_SYNC_START = 18;
   localparam int H_SYNC_END   = 20;
   localparam int H_TOTAL      = 24;
   localparam int V_ACTIVE     = 8;
   localparam int V_SYNC_START = 9;
   localparam int V_SYNC_END   = 10;
   localparam int V_TOTAL      = 12;
   localparam int CAM_W        = 12;
   localparam int CAM_H        = 6;
   localparam int READ_LATENCY = 2;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

   // one check: inputs to apply, where to look and what to see
   typedef struct packed {
      int         id;
      int         button;
      hcount_t    red_x;
      vcount_t    red_y;
      hcount_t    green_x;
      vcount_t    green_y;
      int         frame;
      int         h;
      int         v;
      rgb_t       exp_rgb;
      logic [2:0] exp_sync;
   } vector_t;

   logic       clk;
   logic       rst_n;
   logic       select_button;
   hcount_t    red_x;
   vcount_t    red_y;
   hcount_t    green_x;
   vcount_t    green_y;
   vram_addr_t vram_addr;
   vram_word_t vram_data;
   logic [7:0] red;
   logic [7:0] green;
   logic [7:0] blue;
   logic       hsync;
   logic       vsync;
   logic       blank_b;

   vector_t    vectors[$];
   vram_addr_t addr_pipe [READ_LATENCY];
   // rising edges since reset release
   int         edge_count;
   int         cycle_count;
   int         timeout_limit;

   tracker_display_top #(
      .H_ACTIVE     (H_ACTIVE),
      .H_SYNC_START (H_SYNC_START),
      .H_SYNC_END   (H_SYNC_END),
      .H_TOTAL      (H_TOTAL),
      .V_ACTIVE     (V_ACTIVE),
      .V_SYNC_START (V_SYNC_START),
      .V_SYNC_END   (V_SYNC_END),
      .V_TOTAL      (V_TOTAL),
      .CAM_W        (CAM_W),
      .CAM_H        (CAM_H),
      .READ_LATENCY (READ_LATENCY)
   ) dut_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .select_button (select_button),
      .red_x         (red_x),
      .red_y         (red_y),
      .green_x       (green_x),
      .green_y       (green_y),
      .vram_addr     (vram_addr),
      .vram_data     (vram_data),
      .red           (red),
      .green         (green),
      .blue          (blue),
      .hsync         (hsync),
      .vsync         (vsync),
      .blank_b       (blank_b)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // frame buffer model
   ////////////////////////////////////////////////////////////

   // even pixel holds the address bits, odd pixel their inverse
   function automatic vram_word_t mem_word(input vram_addr_t a);
      return {a[17:0], ~a[17:0]};
   endfunction

   always @(posedge clk) begin
      addr_pipe[0] <= vram_addr;
      for (int i = 1; i < READ_LATENCY; i++)
         addr_pipe[i] <= addr_pipe[i-1];
   end

   assign vram_data = mem_word(addr_pipe[READ_LATENCY-1]);

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         edge_count <= 0;
      else
         edge_count <= edge_count + 1;
   end

   ////////////////////////////////////////////////////////////
   // failure reporting and checks
   ////////////////////////////////////////////////////////////

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "%s", reason);
   endtask

   task automatic check_rgb(input int id, input rgb_t expected, input rgb_t actual);
      if (actual !== expected) begin
         $display("MISMATCH test %0d color expected %06h actual %06h",
                  id, expected, actual);
         fail_run("output color differs from the expected color");
      end
   endtask

   // bits are hsync, vsync, blank_b
   task automatic check_sync(input int id, input logic [2:0] expected,
                             input logic [2:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH test %0d sync expected %03b actual %03b",
                  id, expected, actual);
         fail_run("output syncs or blank differ from the expected levels");
      end
   endtask

   // watchdog over the whole run
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (timeout_limit > 0 && cycle_count >= timeout_limit)
         fail_run("simulation hung, the cycle limit was reached");
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   task automatic read_vectors();
      int         fd;
      int         n;
      string      line;
      vector_t    vec;
      int         id;
      int         button;
      int         rx;
      int         ry;
      int         gx;
      int         gy;
      int         frame;
      int         h;
      int         v;
      rgb_t       rgb;
      logic [2:0] sync;
      fd = $fopen("test/frame_vectors.txt", "r");
      if (fd == 0)
         fail_run("cannot open the vector file test/frame_vectors.txt");
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %h %b",
                     id, button, rx, ry, gx, gy, frame, h, v, rgb, sync);
         // comment and empty lines give no fields
         if (n == 11) begin
            vec.id       = id;
            vec.button   = button;
            vec.red_x    = hcount_t'(rx);
            vec.red_y    = vcount_t'(ry);
            vec.green_x  = hcount_t'(gx);
            vec.green_y  = vcount_t'(gy);
            vec.frame    = frame;
            vec.h        = h;
            vec.v        = v;
            vec.exp_rgb  = rgb;
            vec.exp_sync = sync;
            vectors.push_back(vec);
         end else if (n > 0) begin
            fail_run("malformed line in the vector file");
         end
      end
      $fclose(fd);
      if (vectors.size() == 0)
         fail_run("the vector file holds no vectors");
   endtask

   // 1 pulse, 2 press and hold, 3 release
   task automatic apply_button(input int action);
      case (action)
         1: begin
            select_button = 1'b1;
            @(negedge clk);
            select_button = 1'b0;
         end
         2: select_button = 1'b1;
         3: select_button = 1'b0;
         default: ;
      endcase
   endtask

   initial begin
      int      max_frame;
      int      target;
      int      sample_pos;
      vector_t vec;

      rst_n         = 1'b0;
      select_button = 1'b0;
      red_x         = '0;
      red_y         = '0;
      green_x       = '0;
      green_y       = '0;

      read_vectors();
      max_frame = 0;
      foreach (vectors[i]) begin
         if (vectors[i].frame > max_frame)
            max_frame = vectors[i].frame;
      end
      timeout_limit = vectors.size() * (max_frame + 2) * FRAME_CYCLES;

      // outputs idle during reset, syncs high and blank_b low
      repeat (2) @(negedge clk);
      check_rgb(0, '0, {red, green, blue});
      check_sync(0, 3'b110, {hsync, vsync, blank_b});
      rst_n = 1'b1;

      foreach (vectors[i]) begin
         vec = vectors[i];
         // frames counted from the one the raster shows now
         target = (edge_count / FRAME_CYCLES) + vec.frame;
         // markers and button change in the vertical blanking before it
         while (edge_count < (target - 1) * FRAME_CYCLES + V_ACTIVE * H_TOTAL)
            @(negedge clk);
         red_x   = vec.red_x;
         red_y   = vec.red_y;
         green_x = vec.green_x;
         green_y = vec.green_y;
         apply_button(vec.button);
         // outputs lag the raster counters by one edge
         sample_pos = target * FRAME_CYCLES + vec.v * H_TOTAL + vec.h;
         while (edge_count - 1 < sample_pos)
            @(negedge clk);
         check_rgb(vec.id, vec.exp_rgb, {red, green, blue});
         check_sync(vec.id, vec.exp_sync, {hsync, vsync, blank_b});
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
logic/tracker_pkg.sv
logic/raster_timing.sv
logic/frame_fetch.sv
logic/marker_overlay.sv
logic/video_out.sv
logic/tracker_display_top.sv
test/tracker_tb.sv

/* Makefile */
# Verilator build for the hand tracker display path

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tracker_tb
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/frame_vectors.txt */
# id btn red_x red_y green_x green_y frame h v rgb(hex) hsync_vsync_blank_b(bin)
# btn 0 none, 1 pulse, 2 press and hold, 3 release; frame counts on from the current one
 1 0 1 0  8 4 1  0  0 000000 111
 2 0 1 0  8 4 1  1  0 fcfcfc 111
 3 0 1 0  8 4 1  2  1 002004 111
 4 0 1 0  8 4 1  7  2 fcbcf0 111
 5 0 1 0  8 4 1  5  3 fc9cf4 111
 6 0 1 0  8 4 1 13  2 000000 111
 7 0 1 0  8 4 1 12  6 000000 111
 8 0 1 0  8 4 1  8  0 30ff30 111
 9 0 1 0  8 4 1 11  1 30ff30 111
10 0 1 0  8 4 1  0  4 30ff30 111
11 0 1 0  8 4 1  3  7 30ff30 111
12 0 1 0  8 4 1 16  0 000000 110
13 0 1 0  8 4 1 18  1 000000 010
14 0 1 0  8 4 1 20  2 000000 110
15 0 1 0  8 4 1  0  8 000000 110
16 0 1 0  8 4 1  5  9 000000 100
17 0 1 0  8 4 1 18  9 000000 000
18 0 1 0  8 4 1  0 10 000000 110
19 1 1 0  8 4 1  1  5 ff3030 111
20 0 1 0  8 4 1  8  5 00a010 111
21 1 1 0  8 4 1  8  0 30ff30 111
22 2 1 0  8 4 1  4  5 ff3030 111
23 0 1 0  8 4 3 11  0 ff3030 111
24 3 1 0  8 4 1  6  4 00800c 111
25 1 1 0 12 2 1 13  1 30ff30 111
26 0 1 0 12 2 1  0  5 30ff30 111
